// File: rtl/exec_cfg.svh
////////////////////////////////////////////////////////////////////////////
// Execute slice configuration
// Data width, RV32E mode and the register file geometry derived from it
////////////////////////////////////////////////////////////////////////////

`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Register and result width
`define EXEC_DATA_WIDTH 32

// 1 selects the 16-register RV32E file
`define EXEC_RV32E 0

// Register address width follows the RV32E choice
`define EXEC_REG_AW ((`EXEC_RV32E != 0) ? 4 : 5)

// Number of architectural registers, x0 included
`define EXEC_NUM_REGS (1 << `EXEC_REG_AW)

`endif

// File: rtl/exec_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Execute slice package
// Opcode and writeback state types shared by the RTL and the testbench
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package exec_pkg;

  // Issue opcodes, ALU group first and shifts last
  typedef enum logic [3:0] {
    OP_LI   = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SLT  = 4'd6,
    OP_SLTU = 4'd7,
    OP_SLL  = 4'd8,
    OP_SRL  = 4'd9,
    OP_SRA  = 4'd10
  } exec_op_e;

  // Writeback stage state
  typedef enum logic {
    WB_IDLE   = 1'b0,
    WB_RESULT = 1'b1
  } wb_state_e;

endpackage

`default_nettype wire

// File: rtl/exec_regfile.sv
////////////////////////////////////////////////////////////////////////////
// Integer register file
// Two combinational read ports, one write port, x0 hardwired to zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_regfile (
  input  wire logic                        clk_int,
  input  wire logic                        rst_ni,
  input  wire logic [`EXEC_REG_AW-1:0]     raddr_a_i,
  input  wire logic [`EXEC_REG_AW-1:0]     raddr_b_i,
  output      logic [`EXEC_DATA_WIDTH-1:0] rdata_a_o,
  output      logic [`EXEC_DATA_WIDTH-1:0] rdata_b_o,
  input  wire logic [`EXEC_REG_AW-1:0]     waddr_i,
  input  wire logic [`EXEC_DATA_WIDTH-1:0] wdata_i,
  input  wire logic                        we_i
);

  localparam int unsigned DW = `EXEC_DATA_WIDTH;
  localparam int unsigned AW = `EXEC_REG_AW;
  localparam int unsigned NW = `EXEC_NUM_REGS;

  // Stored words, x0 has no storage
  logic [DW-1:0] mem_q [1:NW-1];
  // Read view with x0 as constant zero
  logic [DW-1:0] rf_words [NW];
  // One-hot write select, word 0 excluded
  logic [NW-1:1] word_en;

  always_comb begin
    for (int i = 1; i < NW; i++) begin
      word_en[i] = we_i && (waddr_i == AW'(i));
    end
  end

  assign rf_words[0] = '0;

  for (genvar w = 1; w < NW; w++) begin : g_word
    // Each word loads only when selected
    always_ff @(posedge clk_int or negedge rst_ni) begin
      if (!rst_ni) begin
        mem_q[w] <= '0;
      end else if (word_en[w]) begin
        mem_q[w] <= wdata_i;
      end
    end

    assign rf_words[w] = mem_q[w];
  end

  // Read muxes
  assign rdata_a_o = rf_words[raddr_a_i];
  assign rdata_b_o = rf_words[raddr_b_i];

  // A write reads back next cycle, a write to x0 still reads zero
  a_write_readback : assert property (@(posedge clk_int) disable iff (!rst_ni)
    we_i |=>
      ((raddr_a_i != $past(waddr_i)) ||
       (rdata_a_o == (($past(waddr_i) == '0) ? '0 : $past(wdata_i)))) &&
      ((raddr_b_i != $past(waddr_i)) ||
       (rdata_b_o == (($past(waddr_i) == '0) ? '0 : $past(wdata_i)))));

endmodule

`default_nettype wire

// File: rtl/exec_alu.sv
////////////////////////////////////////////////////////////////////////////
// Arithmetic and logic unit
// Load-immediate, add/sub, bitwise logic and signed/unsigned compare
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_alu
  import exec_pkg::*;
(
  input  wire logic                        issue_valid_i,
  input  wire exec_op_e                    op_i,
  input  wire logic [`EXEC_DATA_WIDTH-1:0] opa_i,
  input  wire logic [`EXEC_DATA_WIDTH-1:0] opb_i,
  input  wire logic [`EXEC_DATA_WIDTH-1:0] imm_i,
  output      logic                        claim_o,
  output      logic [`EXEC_DATA_WIDTH-1:0] result_o
);

  localparam int unsigned DW = `EXEC_DATA_WIDTH;

  logic          is_sub;
  logic [DW-1:0] opb_add;
  logic [DW:0]   sum;
  logic          slt;
  logic          sltu;
  logic          own_op;

  // Shared adder, anything but ADD subtracts
  assign is_sub  = (op_i != OP_ADD);
  assign opb_add = is_sub ? ~opb_i : opb_i;
  assign sum     = {1'b0, opa_i} + {1'b0, opb_add} + {{DW{1'b0}}, is_sub};

  // No carry out means borrow
  assign sltu = ~sum[DW];
  // Differing signs decide directly, else sign of difference
  assign slt  = (opa_i[DW-1] ^ opb_i[DW-1]) ? opa_i[DW-1] : sum[DW-1];

  always_comb begin
    own_op   = 1'b1;
    result_o = '0;
    case (op_i)
      OP_LI:   result_o = imm_i;
      OP_ADD,
      OP_SUB:  result_o = sum[DW-1:0];
      OP_AND:  result_o = opa_i & opb_i;
      OP_OR:   result_o = opa_i | opb_i;
      OP_XOR:  result_o = opa_i ^ opb_i;
      OP_SLT:  result_o = {{(DW-1){1'b0}}, slt};
      OP_SLTU: result_o = {{(DW-1){1'b0}}, sltu};
      default: own_op   = 1'b0;
    endcase
  end

  assign claim_o = issue_valid_i && own_op;

endmodule

`default_nettype wire

// File: rtl/exec_shifter.sv
////////////////////////////////////////////////////////////////////////////
// Barrel shifter
// SLL, SRL and SRA through a single right-shift barrel
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_shifter
  import exec_pkg::*;
(
  input  wire logic                        issue_valid_i,
  input  wire exec_op_e                    op_i,
  input  wire logic [`EXEC_DATA_WIDTH-1:0] opa_i,
  input  wire logic [`EXEC_DATA_WIDTH-1:0] opb_i,
  output      logic                        claim_o,
  output      logic [`EXEC_DATA_WIDTH-1:0] result_o
);

  localparam int unsigned DW = `EXEC_DATA_WIDTH;

  logic          is_left;
  logic          fill;
  logic [4:0]    shamt;
  logic [DW-1:0] opa_rev;
  logic [DW-1:0] res_rev;
  logic [DW-1:0] stage [6];

  assign is_left = (op_i == OP_SLL);
  // Sign fill only for SRA
  assign fill    = (op_i == OP_SRA) && opa_i[DW-1];
  assign shamt   = opb_i[4:0];

  // Bit reversal turns a left shift into a right shift
  always_comb begin
    for (int i = 0; i < DW; i++) begin
      opa_rev[i] = opa_i[DW-1-i];
      res_rev[i] = stage[5][DW-1-i];
    end
  end

  assign stage[0] = is_left ? opa_rev : opa_i;

  // Log stages, shift by 1, 2, 4, 8, 16
  for (genvar k = 0; k < 5; k++) begin : g_stage
    assign stage[k+1] = shamt[k] ? {{(1 << k){fill}}, stage[k][DW-1:(1 << k)]} : stage[k];
  end

  assign result_o = is_left ? res_rev : stage[5];

  // Claims the three shift opcodes only
  assign claim_o = issue_valid_i && ((op_i == OP_SLL) || (op_i == OP_SRL) || (op_i == OP_SRA));

endmodule

`default_nettype wire

// File: rtl/exec_writeback.sv
////////////////////////////////////////////////////////////////////////////
// Writeback stage
// Registers the claimed unit result and drives regfile write and result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_writeback
  import exec_pkg::*;
(
  input  wire logic                        clk_int,
  input  wire logic                        rst_ni,
  input  wire logic                        alu_claim_i,
  input  wire logic [`EXEC_DATA_WIDTH-1:0] alu_result_i,
  input  wire logic                        shf_claim_i,
  input  wire logic [`EXEC_DATA_WIDTH-1:0] shf_result_i,
  input  wire logic [`EXEC_REG_AW-1:0]     rd_i,
  output      logic                        rf_we_o,
  output      logic [`EXEC_REG_AW-1:0]     rf_waddr_o,
  output      logic [`EXEC_DATA_WIDTH-1:0] rf_wdata_o,
  output      logic                        result_valid_o,
  output      logic [`EXEC_REG_AW-1:0]     result_rd_o,
  output      logic [`EXEC_DATA_WIDTH-1:0] result_data_o
);

  wb_state_e                   state_q;
  logic                        any_claim;
  logic [`EXEC_DATA_WIDTH-1:0] data_q;
  logic [`EXEC_REG_AW-1:0]     rd_q;

  assign any_claim = alu_claim_i || shf_claim_i;

  // One result cycle per claimed issue
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WB_IDLE;
    end else begin
      state_q <= any_claim ? WB_RESULT : WB_IDLE;
    end
  end

  // Result payload
  always_ff @(posedge clk_int) begin
    if (any_claim) begin
      data_q <= alu_claim_i ? alu_result_i : shf_result_i;
      rd_q   <= rd_i;
    end
  end

  assign result_valid_o = (state_q == WB_RESULT);
  assign result_rd_o    = rd_q;
  assign result_data_o  = data_q;

  // Same cycle drives the regfile write
  assign rf_we_o    = result_valid_o;
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = data_q;

  // ALU and shifter opcode sets are disjoint
  a_single_claim : assert property (@(posedge clk_int) disable iff (!rst_ni)
    !(alu_claim_i && shf_claim_i));

endmodule

`default_nettype wire

// File: rtl/exec_core.sv
////////////////////////////////////////////////////////////////////////////
// Integer execute slice
// Register file, ALU and shifter in parallel, then one writeback stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_core
  import exec_pkg::*;
(
  input  wire logic                        clk_int,
  input  wire logic                        rst_ni,
  input  wire logic                        issue_valid_i,
  input  wire exec_op_e                    issue_op_i,
  input  wire logic [`EXEC_REG_AW-1:0]     issue_rd_i,
  input  wire logic [`EXEC_REG_AW-1:0]     issue_rs1_i,
  input  wire logic [`EXEC_REG_AW-1:0]     issue_rs2_i,
  input  wire logic [`EXEC_DATA_WIDTH-1:0] issue_imm_i,
  output      logic                        result_valid_o,
  output      logic [`EXEC_REG_AW-1:0]     result_rd_o,
  output      logic [`EXEC_DATA_WIDTH-1:0] result_data_o
);

  // Operands from the regfile
  logic [`EXEC_DATA_WIDTH-1:0] opa;
  logic [`EXEC_DATA_WIDTH-1:0] opb;

  // Unit claims and results
  logic                        alu_claim;
  logic [`EXEC_DATA_WIDTH-1:0] alu_result;
  logic                        shf_claim;
  logic [`EXEC_DATA_WIDTH-1:0] shf_result;

  // Regfile write port
  logic                        rf_we;
  logic [`EXEC_REG_AW-1:0]     rf_waddr;
  logic [`EXEC_DATA_WIDTH-1:0] rf_wdata;

  exec_regfile u_regfile (
    .clk_int   (clk_int),
    .rst_ni    (rst_ni),
    .raddr_a_i (issue_rs1_i),
    .raddr_b_i (issue_rs2_i),
    .rdata_a_o (opa),
    .rdata_b_o (opb),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  exec_alu u_alu (
    .issue_valid_i (issue_valid_i),
    .op_i          (issue_op_i),
    .opa_i         (opa),
    .opb_i         (opb),
    .imm_i         (issue_imm_i),
    .claim_o       (alu_claim),
    .result_o      (alu_result)
  );

  exec_shifter u_shifter (
    .issue_valid_i (issue_valid_i),
    .op_i          (issue_op_i),
    .opa_i         (opa),
    .opb_i         (opb),
    .claim_o       (shf_claim),
    .result_o      (shf_result)
  );

  // Result goes back to the regfile and out
  exec_writeback u_writeback (
    .clk_int        (clk_int),
    .rst_ni         (rst_ni),
    .alu_claim_i    (alu_claim),
    .alu_result_i   (alu_result),
    .shf_claim_i    (shf_claim),
    .shf_result_i   (shf_result),
    .rd_i           (issue_rd_i),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_exec_core.sv
////////////////////////////////////////////////////////////////////////////
// Execute slice testbench
// Issues instructions from the testdata file and checks each writeback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module tb_exec_core
  import exec_pkg::*;
();

  logic                        clk_int;
  logic                        rst_ni;
  logic                        issue_valid;
  exec_op_e                    issue_op;
  logic [`EXEC_REG_AW-1:0]     issue_rd;
  logic [`EXEC_REG_AW-1:0]     issue_rs1;
  logic [`EXEC_REG_AW-1:0]     issue_rs2;
  logic [`EXEC_DATA_WIDTH-1:0] issue_imm;
  logic                        result_valid;
  logic [`EXEC_REG_AW-1:0]     result_rd;
  logic [`EXEC_DATA_WIDTH-1:0] result_data;

  // Test table from the data file
  logic [31:0] op_q[$];
  logic [31:0] rd_q[$];
  logic [31:0] rs1_q[$];
  logic [31:0] rs2_q[$];
  logic [31:0] imm_q[$];
  logic [31:0] exp_q[$];
  string       name_q[$];

  int errors = 0;
  int failed_tests = 0;
  int cycles = 0;
  int limit = 0;

  exec_core uut (
    .clk_int        (clk_int),
    .rst_ni         (rst_ni),
    .issue_valid_i  (issue_valid),
    .issue_op_i     (issue_op),
    .issue_rd_i     (issue_rd),
    .issue_rs1_i    (issue_rs1),
    .issue_rs2_i    (issue_rs2),
    .issue_imm_i    (issue_imm),
    .result_valid_o (result_valid),
    .result_rd_o    (result_rd),
    .result_data_o  (result_data)
  );

  // 100 ns clock
  initial begin
    clk_int = 1'b0;
    forever #50 clk_int = ~clk_int;
  end

  // Watchdog
  always @(posedge clk_int) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test, what, expected, actual);
    end
  endtask

  // Skips blank lines and lines starting with #
  task automatic load_tests();
    int    fd;
    int    code;
    string line;
    logic [31:0] f_op;
    logic [31:0] f_rd;
    logic [31:0] f_rs1;
    logic [31:0] f_rs2;
    logic [31:0] f_imm;
    logic [31:0] f_exp;
    string f_name;
    fd = $fopen("tb/exec_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/exec_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 1 && line.getc(0) != "#") begin
          code = $sscanf(line, "%h %h %h %h %h %h %s",
                         f_op, f_rd, f_rs1, f_rs2, f_imm, f_exp, f_name);
          if (code == 7) begin
            op_q.push_back(f_op);
            rd_q.push_back(f_rd);
            rs1_q.push_back(f_rs1);
            rs2_q.push_back(f_rs2);
            imm_q.push_back(f_imm);
            exp_q.push_back(f_exp);
            name_q.push_back(f_name);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int idle;
    int err_before;
    issue_valid = 1'b0;
    issue_op    = OP_LI;
    issue_rd    = '0;
    issue_rs1   = '0;
    issue_rs2   = '0;
    issue_imm   = '0;
    rst_ni      = 1'b0;
    void'($urandom(69000));
    load_tests();
    limit = name_q.size() * 5 + 20;

    // Two cycles of reset
    repeat (2) @(posedge clk_int);
    #1 rst_ni = 1'b1;
    @(posedge clk_int);
    #1;
    err_before = errors;
    check_value("after_reset", "valid", 32'd0, 32'(result_valid));
    $display("test %-12s %s", "after_reset", (errors == err_before) ? "ok" : "failed");
    if (errors != err_before) failed_tests++;

    foreach (name_q[i]) begin
      err_before = errors;
      // Issue cycle
      issue_valid = 1'b1;
      issue_op    = exec_op_e'(op_q[i][3:0]);
      issue_rd    = rd_q[i][`EXEC_REG_AW-1:0];
      issue_rs1   = rs1_q[i][`EXEC_REG_AW-1:0];
      issue_rs2   = rs2_q[i][`EXEC_REG_AW-1:0];
      issue_imm   = imm_q[i];
      @(posedge clk_int);
      #1;
      issue_valid = 1'b0;
      // Result cycle
      check_value(name_q[i], "valid", 32'd1, 32'(result_valid));
      check_value(name_q[i], "rd", rd_q[i], 32'(result_rd));
      check_value(name_q[i], "data", exp_q[i], result_data);
      // Idle gap, also lets the write land
      idle = 1 + int'($urandom % 3);
      repeat (idle) begin
        @(posedge clk_int);
        #1;
        check_value(name_q[i], "idle valid", 32'd0, 32'(result_valid));
      end
      $display("test %-12s %s", name_q[i], (errors == err_before) ? "ok" : "failed");
      if (errors != err_before) failed_tests++;
    end

    $display("Tests run %0d, tests failed %0d, mismatches %0d",
             name_q.size() + 1, failed_tests, errors);
    if (errors == 0 && name_q.size() > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: exec_core.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/exec_regfile.sv
rtl/exec_alu.sv
rtl/exec_shifter.sv
rtl/exec_writeback.sv
rtl/exec_core.sv
tb/tb_exec_core.sv

// File: Makefile
# Verilator simulation of the execute slice testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_core
FLIST     ?= exec_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/exec_testdata.txt
# Columns in hex: op rd rs1 rs2 imm expected, then the test name
# op: 0 LI, 1 ADD, 2 SUB, 3 AND, 4 OR, 5 XOR, 6 SLT, 7 SLTU, 8 SLL, 9 SRL, a SRA
0 01 00 00 00000005 00000005 li_x1
0 02 00 00 fffffff0 fffffff0 li_x2
0 03 00 00 0000001f 0000001f li_x3
0 04 00 00 00000001 00000001 li_x4
0 05 00 00 80000000 80000000 li_x5
1 06 01 02 00000000 fffffff5 add_neg
2 07 01 03 00000000 ffffffe6 sub_wrap
3 08 02 03 00000000 00000010 and_mask
4 09 01 02 00000000 fffffff5 or_mix
5 0a 01 03 00000000 0000001a xor_mix
6 0b 02 01 00000000 00000001 slt_neg
7 0c 02 01 00000000 00000000 sltu_neg
7 0d 01 02 00000000 00000001 sltu_pos
8 0e 01 00 00000000 00000005 sll_0
8 0f 03 04 00000000 0000003e sll_1
8 10 04 03 00000000 80000000 sll_31
9 11 02 03 00000000 00000001 srl_31
9 12 05 04 00000000 40000000 srl_1
a 13 02 03 00000000 ffffffff sra_31
a 14 05 04 00000000 c0000000 sra_1
a 15 02 00 00000000 fffffff0 sra_0
0 00 00 00 12345678 12345678 li_x0
1 16 00 01 00000000 00000005 add_x0
1 17 16 16 00000000 0000000a add_dep
